// File: verification/slc3Tests.dat
# columns: command, hex address or LED value, hex data or expected word
# W addr data = loader write, G = run, P led = wait for pause, C = continue, M addr value = check
W 0000 6C3F # ldr r6, r0, #-1 (wraps to 3ff)
W 0001 6380 # ldr r1, r6, #0
W 0002 6581 # ldr r2, r6, #1
W 0003 1642 # add r3, r1, r2
W 0004 77BF # str r3, r6, #-1
W 0005 1879 # add r4, r1, #-7
W 0006 79BE # str r4, r6, #-2
W 0007 5A42 # and r5, r1, r2
W 0008 7B82
W 0009 5AAF # and r5, r2, #15
W 000A 7B83
W 000B 9ABF # not r5, r2
W 000C 7B84
W 000D D001 # pause 001
W 000E 1221 # r1 = 1 marker
W 000F 54A0 # cc z
W 0010 0A01 # brnp not taken
W 0011 7385
W 0012 0401 # brz taken
W 0013 7386
W 0014 163D # r3 = -3, cc n
W 0015 0601 # brzp not taken
W 0016 7787
W 0017 0801 # brn taken
W 0018 7788
W 0019 1829 # r4 = 9, cc p
W 001A 0C01 # brnz not taken
W 001B 7989
W 001C 0201 # brp taken
W 001D 798A
W 001E 0E01 # brnzp taken
W 001F 798B
W 0020 4809 # jsr to 02a
W 0021 1225 # r1 = 5 after return
W 0022 738D
W 0023 D002 # pause 002
W 0024 65BF # ldr r2, r6, #-1
W 0025 17AF # r3 = base + 15
W 0026 74C1 # str r2, r3, #1
W 0027 68F2 # ldr r4, r3, #-14
W 0028 78C2 # str r4, r3, #2
W 0029 D0AB # pause 0ab
W 002A 7F8C # subroutine, store r7
W 002B C1C0 # jmp r7
W 002C 7F8E
W 03FF 0100 # base pointer
W 0100 1234
W 0101 8F0F
W 0106 0000
W 0108 0000
W 010A 0000
W 010B 0000
W 010E 0000
M 0000 6C3F
M 03FF 0100
M 0106 0000
G
P 001
M 00FF A143
M 00FE 122D
M 0102 0204
M 0103 000F
M 0104 70F0
C
P 002
M 0105 0001
M 0106 0000
M 0107 FFFD
M 0108 0000
M 0109 0009
M 010A 0000
M 010B 0000
M 010C 0021
M 010D 0005
M 010E 0000
W 0101 5A5A # new operand written during pause
C
P 0AB
M 0110 A143
M 0111 5A5A
M 0100 1234

// File: slc3Top.f
common/lc3Pkg.sv
datapath/regFile.sv
datapath/datapath.sv
design/controlUnit.sv
design/memory.sv
design/slc3Top.sv
verification/slc3Tb.sv

// File: run.sh
#!/bin/sh
# build and run the slc3 regression with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module slc3Tb -Mdir obj_dir -f slc3Top.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vslc3Tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" "$LOG"; then
	exit 1
fi
exit 0

// File: verification/slc3Tb.sv
`timescale 1ns/1ps

module slc3Tb import lc3Pkg::*; ();

	logic Clk;
	logic rst;
	logic Run;
	logic Continue;
	logic loadEn;
	logic loadWe;
	memAddr_t loadAddr;
	word_t loadData;
	word_t loadRdata;
	logic [11:0] ledOut;
	logic paused;

	byte cmdOp [$];
	word_t cmdArgA [$];
	word_t cmdArgB [$];
	int checkCount = 0;
	int errorCount = 0;
	int limitCycles = 0;
	bit fileOk = 1'b0;

	slc3Top UUT (
		.Clk(Clk),
		.rst(rst),
		.Run(Run),
		.Continue(Continue),
		.loadEn(loadEn),
		.loadWe(loadWe),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.loadRdata(loadRdata),
		.ledOut(ledOut),
		.paused(paused)
	);

	initial
	begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk;
	end

	task automatic compareValue(input string name, input word_t got, input word_t expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	// one command per line, comments start with #
	task automatic readTests();
		int fd;
		string line;
		word_t argA;
		word_t argB;
		fd = $fopen("verification/slc3Tests.dat", "r");
		if (fd != 0)
		begin
			fileOk = 1'b1;
			while ($fgets(line, fd) > 0)
			begin
				if (line[0] != "#" && line[0] != "\n")
				begin
					argA = '0;
					argB = '0;
					void'($sscanf(line.substr(1, line.len() - 1), "%h %h", argA, argB));
					cmdOp.push_back(line[0]);
					cmdArgA.push_back(argA);
					cmdArgB.push_back(argB);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic loadWord(input word_t addr, input word_t data);
		@(posedge Clk);
		#1;
		loadEn = 1'b1;
		loadWe = 1'b1;
		loadAddr = addr[MEM_ADDR_BITS-1:0];
		loadData = data;
		@(posedge Clk);
		#1;
		loadEn = 1'b0;
		loadWe = 1'b0;
	endtask

	task automatic checkMemory(input word_t addr, input word_t expected);
		@(posedge Clk);
		#1 loadAddr = addr[MEM_ADDR_BITS-1:0];
		@(negedge Clk); // loader read path is combinational
		compareValue($sformatf("mem[%03h]", addr), loadRdata, expected);
	endtask

	task automatic pulseRun();
		@(posedge Clk);
		#1 Run = 1'b1;
		@(posedge Clk);
		#1 Run = 1'b0;
	endtask

	task automatic waitForPause(input word_t expLed);
		@(negedge Clk);
		while (!paused)
			@(negedge Clk);
		@(negedge Clk); // led latch fills one cycle into the pause
		compareValue("ledOut", {4'b0, ledOut}, expLed);
	endtask

	task automatic continueRun();
		int hold;
		hold = 2 + int'($urandom % 8);
		@(posedge Clk);
		#1 Continue = 1'b1;
		repeat (hold) @(posedge Clk);
		#1 Continue = 1'b0;
		while (paused)
			@(negedge Clk); // cpu resumes fetching
	endtask

	task automatic runCommand(input byte op, input word_t argA, input word_t argB);
		case (op)
			"W": loadWord(argA, argB);
			"G": pulseRun();
			"P": waitForPause(argA);
			"C": continueRun();
			"M": checkMemory(argA, argB);
			default:
			begin
				errorCount++;
				$display("unknown command '%c' in the tests file", op);
			end
		endcase
	endtask

	initial
	begin
		rst = 1'b1;
		Run = 1'b0;
		Continue = 1'b0;
		loadEn = 1'b0;
		loadWe = 1'b0;
		loadAddr = '0;
		loadData = '0;
		void'($urandom(32'hc252));
		readTests();
		if (!fileOk)
		begin
			$display("could not open verification/slc3Tests.dat for reading");
			$display("Regression failed");
			$finish;
		end
		else
		begin
			limitCycles = 300 * cmdOp.size();
			repeat (5) @(posedge Clk);
			#1 rst = 1'b0;
			@(negedge Clk);
			compareValue("paused", {15'b0, paused}, 16'h0000);
			compareValue("ledOut", {4'b0, ledOut}, 16'h0000);
			foreach (cmdOp[i])
				runCommand(cmdOp[i], cmdArgA[i], cmdArgB[i]);
			$display("%0d checks, %0d errors", checkCount, errorCount);
			if (errorCount == 0)
				$display("Regression passed");
			else
				$display("Regression failed");
			$finish;
		end
	end

	// run length scales with the number of commands
	initial
	begin
		wait (limitCycles > 0);
		repeat (limitCycles) @(posedge Clk);
		$display("timeout, the tests did not finish within %0d clock cycles", limitCycles);
		$display("Regression failed");
		$finish;
	end

endmodule

// File: design/slc3Top.sv
`timescale 1ns/1ps

module slc3Top import lc3Pkg::*; (
	input logic Clk,
	input logic rst,
	input logic Run,
	input logic Continue,
	input logic loadEn,
	input logic loadWe,
	input memAddr_t loadAddr,
	input word_t loadData,
	output word_t loadRdata,
	output logic [11:0] ledOut,
	output logic paused
);

	logic ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed;
	logic gatePc, gateMdr, gateAlu, gateMarmux;
	logic [1:0] pcMux, addr2Mux;
	logic drMux, sr1Mux, sr2Mux, addr1Mux;
	aluOp_t aluk;
	opcode_t opcode;
	logic ir5, ir11, ben;
	logic memOe, memWe;
	word_t mar, mdr, memRdata;

	controlUnit ctrl (
		.Clk(Clk), .rst(rst), .Run(Run), .Continue(Continue),
		.opcode(opcode), .ir5(ir5), .ir11(ir11), .ben(ben),
		.ldMar(ldMar), .ldMdr(ldMdr), .ldIr(ldIr), .ldBen(ldBen),
		.ldCc(ldCc), .ldReg(ldReg), .ldPc(ldPc), .ldLed(ldLed),
		.gatePc(gatePc), .gateMdr(gateMdr), .gateAlu(gateAlu), .gateMarmux(gateMarmux),
		.pcMux(pcMux), .drMux(drMux), .sr1Mux(sr1Mux), .sr2Mux(sr2Mux),
		.addr1Mux(addr1Mux), .addr2Mux(addr2Mux), .aluk(aluk),
		.memOe(memOe), .memWe(memWe), .paused(paused)
	);

	datapath dp (
		.Clk(Clk), .rst(rst),
		.ldMar(ldMar), .ldMdr(ldMdr), .ldIr(ldIr), .ldBen(ldBen),
		.ldCc(ldCc), .ldReg(ldReg), .ldPc(ldPc), .ldLed(ldLed),
		.gatePc(gatePc), .gateMdr(gateMdr), .gateAlu(gateAlu), .gateMarmux(gateMarmux),
		.pcMux(pcMux), .drMux(drMux), .sr1Mux(sr1Mux), .sr2Mux(sr2Mux),
		.addr1Mux(addr1Mux), .addr2Mux(addr2Mux), .aluk(aluk),
		.memRdata(memRdata),
		.opcode(opcode), .ir5(ir5), .ir11(ir11), .ben(ben),
		.mar(mar), .mdr(mdr), .ledOut(ledOut)
	);

	memory mem (
		.Clk(Clk), .memOe(memOe), .memWe(memWe),
		.addr(mar), .wdata(mdr),
		.loadEn(loadEn), .loadWe(loadWe), .loadAddr(loadAddr), .loadData(loadData),
		.rdata(memRdata), .loadRdata(loadRdata)
	);

endmodule

// File: design/memory.sv
`timescale 1ns/1ps

module memory import lc3Pkg::*; (
	input logic Clk,
	input logic memOe,
	input logic memWe,
	input word_t addr,
	input word_t wdata,
	input logic loadEn,
	input logic loadWe,
	input memAddr_t loadAddr,
	input word_t loadData,
	output word_t rdata,
	output word_t loadRdata
);

	word_t mem [MEM_WORDS];
	memAddr_t cpuAddr;

	assign cpuAddr = addr[MEM_ADDR_BITS-1:0]; // upper bits wrap

	always_ff @(posedge Clk)
	begin
		if (loadEn)
		begin
			if (loadWe) mem[loadAddr] <= loadData;
		end
		else
		begin
			if (!memWe) mem[cpuAddr] <= wdata;
			if (!memOe) rdata <= mem[cpuAddr];
		end
	end

	assign loadRdata = mem[loadAddr];

	// loader must only run while the cpu is halted or paused
	assert property (@(posedge Clk) !(loadEn && !memWe));

endmodule

// File: design/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import lc3Pkg::*; (
	input logic Clk,
	input logic rst,
	input logic Run,
	input logic Continue,
	input opcode_t opcode,
	input logic ir5,
	input logic ir11,
	input logic ben,
	output logic ldMar,
	output logic ldMdr,
	output logic ldIr,
	output logic ldBen,
	output logic ldCc,
	output logic ldReg,
	output logic ldPc,
	output logic ldLed,
	output logic gatePc,
	output logic gateMdr,
	output logic gateAlu,
	output logic gateMarmux,
	output logic [1:0] pcMux,
	output logic drMux,
	output logic sr1Mux,
	output logic sr2Mux,
	output logic addr1Mux,
	output logic [1:0] addr2Mux,
	output aluOp_t aluk,
	output logic memOe,
	output logic memWe,
	output logic paused
);

	typedef enum logic [4:0] {
		halted,
		pauseHold,
		pauseRelease,
		fetchMar,
		fetchRead1,
		fetchRead2,
		fetchRead3,
		fetchIr,
		decode,
		brExec,
		addExec,
		andExec,
		notExec,
		jmpExec,
		jsrExec,
		ldrAddr,
		ldrRead1,
		ldrRead2,
		ldrRead3,
		ldrWrite,
		strAddr,
		strMdr,
		strWrite1,
		strWrite2,
		strWrite3
	} state_t;

	state_t state, nextState;

	always_ff @(posedge Clk)
	begin
		if (rst)
			state <= halted;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		unique case (state)
			halted: if (Run) nextState = fetchMar;
			pauseHold: if (Continue) nextState = pauseRelease; // wait for rising edge
			pauseRelease: if (!Continue) nextState = fetchMar;
			fetchMar: nextState = fetchRead1;
			fetchRead1: nextState = fetchRead2;
			fetchRead2: nextState = fetchRead3;
			fetchRead3: nextState = fetchIr;
			fetchIr: nextState = decode;
			decode:
			begin
				case (opcode)
					OP_BR: nextState = brExec;
					OP_ADD: nextState = addExec;
					OP_AND: nextState = andExec;
					OP_NOT: nextState = notExec;
					OP_JMP: nextState = jmpExec;
					OP_JSR: nextState = ir11 ? jsrExec : fetchMar; // JSRR not supported
					OP_LDR: nextState = ldrAddr;
					OP_STR: nextState = strAddr;
					OP_PAUSE: nextState = pauseHold;
					default: nextState = fetchMar;
				endcase
			end
			ldrAddr: nextState = ldrRead1;
			ldrRead1: nextState = ldrRead2;
			ldrRead2: nextState = ldrRead3;
			ldrRead3: nextState = ldrWrite;
			strAddr: nextState = strMdr;
			strMdr: nextState = strWrite1;
			strWrite1: nextState = strWrite2;
			strWrite2: nextState = strWrite3;
			default: nextState = fetchMar; // single-cycle execute and strWrite3
		endcase
	end

	always_comb
	begin
		ldMar = 1'b0;
		ldMdr = 1'b0;
		ldIr = 1'b0;
		ldBen = 1'b0;
		ldCc = 1'b0;
		ldReg = 1'b0;
		ldPc = 1'b0;
		ldLed = 1'b0;
		gatePc = 1'b0;
		gateMdr = 1'b0;
		gateAlu = 1'b0;
		gateMarmux = 1'b0;
		pcMux = PCMUX_INC;
		drMux = 1'b0;
		sr1Mux = 1'b0;
		sr2Mux = 1'b0;
		addr1Mux = 1'b0;
		addr2Mux = ADDR2_ZERO;
		aluk = ALU_ADD;
		memOe = 1'b1;
		memWe = 1'b1;
		paused = 1'b0;

		case (state)
			pauseHold, pauseRelease:
			begin
				ldLed = 1'b1;
				paused = 1'b1;
			end
			fetchMar:
			begin
				gatePc = 1'b1;
				ldMar = 1'b1;
				ldPc = 1'b1;
			end
			fetchRead1, fetchRead2, fetchRead3, ldrRead1, ldrRead2, ldrRead3:
			begin
				memOe = 1'b0;
				ldMdr = 1'b1; // last load holds the valid word
			end
			fetchIr:
			begin
				gateMdr = 1'b1;
				ldIr = 1'b1;
			end
			decode: ldBen = 1'b1;
			brExec:
			begin
				pcMux = PCMUX_ADDR;
				addr2Mux = ADDR2_OFF9;
				ldPc = ben; // pc moves only on a taken branch
			end
			addExec, andExec, notExec:
			begin
				sr1Mux = 1'b1;
				sr2Mux = ir5;
				aluk = (state == addExec) ? ALU_ADD : (state == andExec) ? ALU_AND : ALU_NOT;
				gateAlu = 1'b1;
				ldReg = 1'b1;
				ldCc = 1'b1;
			end
			jmpExec:
			begin
				sr1Mux = 1'b1;
				addr1Mux = 1'b1;
				pcMux = PCMUX_ADDR;
				ldPc = 1'b1;
			end
			jsrExec:
			begin
				gatePc = 1'b1; // R7 gets the old pc on the same edge
				drMux = 1'b1;
				ldReg = 1'b1;
				addr2Mux = ADDR2_OFF11;
				pcMux = PCMUX_ADDR;
				ldPc = 1'b1;
			end
			ldrAddr, strAddr:
			begin
				sr1Mux = 1'b1;
				addr1Mux = 1'b1;
				addr2Mux = ADDR2_OFF6;
				gateMarmux = 1'b1;
				ldMar = 1'b1;
			end
			ldrWrite:
			begin
				gateMdr = 1'b1;
				ldReg = 1'b1;
				ldCc = 1'b1;
			end
			strMdr:
			begin
				aluk = ALU_PASSA; // source register is IR[11:9]
				gateAlu = 1'b1;
				ldMdr = 1'b1;
			end
			strWrite1, strWrite2, strWrite3: memWe = 1'b0;
			default: ;
		endcase
	end

	assert property (@(posedge Clk) disable iff (rst) !(!memOe && !memWe));
	assert property (@(posedge Clk) disable iff (rst)
		$onehot0({gatePc, gateMdr, gateAlu, gateMarmux}));
	assert property (@(posedge Clk) disable iff (rst)
		!$isunknown(state) && int'(state) <= int'(state.last()));

endmodule

// File: datapath/datapath.sv
`timescale 1ns/1ps

module datapath import lc3Pkg::*; (
	input logic Clk,
	input logic rst,
	input logic ldMar,
	input logic ldMdr,
	input logic ldIr,
	input logic ldBen,
	input logic ldCc,
	input logic ldReg,
	input logic ldPc,
	input logic ldLed,
	input logic gatePc,
	input logic gateMdr,
	input logic gateAlu,
	input logic gateMarmux,
	input logic [1:0] pcMux,
	input logic drMux,
	input logic sr1Mux,
	input logic sr2Mux,
	input logic addr1Mux,
	input logic [1:0] addr2Mux,
	input aluOp_t aluk,
	input word_t memRdata,
	output opcode_t opcode,
	output logic ir5,
	output logic ir11,
	output logic ben,
	output word_t mar,
	output word_t mdr,
	output logic [11:0] ledOut
);

	word_t pc, ir, bus, pcNext;
	word_t sr1Data, sr2Data, aluB, aluOut;
	word_t addr1, addr2, addrSum;
	logic n, z, p;
	logic [3:0] busSel;
	regAddr_t drSel, sr1Sel;

	assign busSel = {gatePc, gateMdr, gateAlu, gateMarmux};

	always_comb
	begin
		case (busSel)
			4'b1000: bus = pc;
			4'b0100: bus = mdr;
			4'b0010: bus = aluOut;
			4'b0001: bus = addrSum; // marmux path
			default: bus = '0;
		endcase
	end

	// address adder shared by pc and marmux
	assign addr1 = addr1Mux ? sr1Data : pc;
	always_comb
	begin
		case (addr2Mux)
			ADDR2_OFF6: addr2 = {{10{ir[5]}}, ir[5:0]};
			ADDR2_OFF9: addr2 = {{7{ir[8]}}, ir[8:0]};
			ADDR2_OFF11: addr2 = {{5{ir[10]}}, ir[10:0]};
			default: addr2 = '0;
		endcase
	end
	assign addrSum = addr1 + addr2;

	always_comb
	begin
		case (pcMux)
			PCMUX_BUS: pcNext = bus;
			PCMUX_ADDR: pcNext = addrSum;
			default: pcNext = pc + 16'd1;
		endcase
	end

	assign aluB = sr2Mux ? {{11{ir[4]}}, ir[4:0]} : sr2Data;
	always_comb
	begin
		case (aluk)
			ALU_ADD: aluOut = sr1Data + aluB;
			ALU_AND: aluOut = sr1Data & aluB;
			ALU_NOT: aluOut = ~sr1Data;
			default: aluOut = sr1Data;
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			pc <= '0;
			ir <= '0;
			{n, z, p} <= 3'b000;
			ben <= 1'b0;
			ledOut <= '0;
		end
		else
		begin
			if (ldPc) pc <= pcNext;
			if (ldIr) ir <= bus;
			if (ldCc) {n, z, p} <= {bus[15], bus == '0, !bus[15] && bus != '0};
			if (ldBen) ben <= (ir[11] & n) | (ir[10] & z) | (ir[9] & p);
			if (ldLed) ledOut <= ir[11:0];
		end
	end

	always_ff @(posedge Clk)
	begin
		if (ldMar) mar <= bus;
		if (ldMdr) mdr <= gateAlu ? bus : memRdata; // alu gate marks a store
	end

	assign drSel = drMux ? 3'd7 : ir[11:9];
	assign sr1Sel = sr1Mux ? ir[8:6] : ir[11:9];

	regFile regs (
		.Clk(Clk),
		.rst(rst),
		.we(ldReg),
		.dr(drSel),
		.sr1(sr1Sel),
		.sr2(ir[2:0]),
		.din(bus),
		.sr1Data(sr1Data),
		.sr2Data(sr2Data)
	);

	assign opcode = ir[15:12];
	assign ir5 = ir[5];
	assign ir11 = ir[11];

	assert property (@(posedge Clk) disable iff (rst) $onehot0(busSel));

endmodule

// File: datapath/regFile.sv
`timescale 1ns/1ps

module regFile import lc3Pkg::*; (
	input logic Clk,
	input logic rst,
	input logic we,
	input regAddr_t dr,
	input regAddr_t sr1,
	input regAddr_t sr2,
	input word_t din,
	output word_t sr1Data,
	output word_t sr2Data
);

	word_t regs [8];

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end
		else if (we)
			regs[dr] <= din;
	end

	assign sr1Data = regs[sr1];
	assign sr2Data = regs[sr2];

endmodule

// File: common/lc3Pkg.sv
package lc3Pkg;

	localparam int MEM_ADDR_BITS = 10;
	localparam int MEM_WORDS = 1 << MEM_ADDR_BITS;

	typedef logic [15:0] word_t;
	typedef logic [2:0] regAddr_t;
	typedef logic [3:0] opcode_t;
	typedef logic [1:0] aluOp_t;
	typedef logic [MEM_ADDR_BITS-1:0] memAddr_t;

	// instruction opcodes, LC-3 encoding
	localparam opcode_t OP_BR = 4'd0;
	localparam opcode_t OP_ADD = 4'd1;
	localparam opcode_t OP_JSR = 4'd4;
	localparam opcode_t OP_AND = 4'd5;
	localparam opcode_t OP_LDR = 4'd6;
	localparam opcode_t OP_STR = 4'd7;
	localparam opcode_t OP_NOT = 4'd9;
	localparam opcode_t OP_JMP = 4'd12;
	localparam opcode_t OP_PAUSE = 4'd13;

	localparam aluOp_t ALU_ADD = 2'd0;
	localparam aluOp_t ALU_AND = 2'd1;
	localparam aluOp_t ALU_NOT = 2'd2;
	localparam aluOp_t ALU_PASSA = 2'd3;

	localparam logic [1:0] PCMUX_INC = 2'd0;
	localparam logic [1:0] PCMUX_BUS = 2'd1;
	localparam logic [1:0] PCMUX_ADDR = 2'd2;

	localparam logic [1:0] ADDR2_ZERO = 2'd0;
	localparam logic [1:0] ADDR2_OFF6 = 2'd1;
	localparam logic [1:0] ADDR2_OFF9 = 2'd2;
	localparam logic [1:0] ADDR2_OFF11 = 2'd3;

endpackage
